//--- logic/vex_pkg.sv
/* widths, multiply latency, unit/op/source/memory enumerations,
   mask word union and the shared element ALU function */
package vex_pkg;

  localparam int XLEN = 32;

  // edges from multiply acceptance to out_valid
  localparam int MUL_LATENCY = 3;
  localparam int MUL_CNT_W = $clog2(MUL_LATENCY);

  // find-first result when the mask is empty
  localparam logic [XLEN-1:0] NO_FIRST = '1;

  typedef enum logic [1:0] {
    FU_ALU,
    FU_MUL,
    FU_MEM,
    FU_FIRST
  } fu_t;

  typedef enum logic [2:0] {
    ADD,
    AND,
    OR,
    XOR,
    MIN,
    MINU,
    MAX,
    MAXU
  } alu_op_t;

  typedef enum logic [1:0] {
    SRC_V,
    SRC_I,
    SRC_X
  } src_kind_t;

  typedef enum logic [1:0] {
    EEW8,
    EEW16,
    EEW32
  } eew_t;

  typedef enum logic [1:0] {
    STRIDE_UNIT,
    STRIDE_CONST,
    STRIDE_SEG
  } stride_kind_t;

  typedef struct packed {
    logic [XLEN-1:0] lane1;
    logic [XLEN-1:0] lane0;
  } lane_pair_t;

  // vs2 held per lane, or read as one 64-bit mask with bit 0 from lane 0
  typedef union packed {
    lane_pair_t          lanes;
    logic [2*XLEN-1:0]   flat;
  } mask_word_u;

  // element op, shared by the lanes and the reduction
  function automatic logic [XLEN-1:0] alu_eval(alu_op_t op, logic [XLEN-1:0] a,
                                               logic [XLEN-1:0] b);
    logic lt_s;
    logic lt_u;
    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;
    case (op)
      ADD:     alu_eval = a + b;
      AND:     alu_eval = a & b;
      OR:      alu_eval = a | b;
      XOR:     alu_eval = a ^ b;
      MIN:     alu_eval = lt_s ? a : b;
      MINU:    alu_eval = lt_u ? a : b;
      MAX:     alu_eval = lt_s ? b : a;
      default: alu_eval = lt_u ? b : a;
    endcase
  endfunction

endpackage

//--- logic/lane_op_if.sv
/* held operands, control and address fields from the operand latch
   to the lane ALUs, the address generator and the result merge */
interface lane_op_if;
  import vex_pkg::*;

  logic [XLEN-1:0] src1_0;
  logic [XLEN-1:0] src1_1;
  logic [XLEN-1:0] src2_0;
  logic [XLEN-1:0] src2_1;
  mask_word_u      mask;
  fu_t             fu;
  alu_op_t         alu_op;
  logic            reduce;

  // memory access fields
  logic [XLEN-1:0] base;
  logic [XLEN-1:0] stride;
  eew_t            eew;
  stride_kind_t    stride_kind;
  logic [2:0]      nf;
  logic [2:0]      nf_count;

  modport latch (output src1_0, src1_1, src2_0, src2_1, mask, fu, alu_op, reduce,
                 base, stride, eew, stride_kind, nf, nf_count);

  modport lane (input src1_0, src1_1, src2_0, src2_1, fu, alu_op);

  modport uses (input src1_0, src1_1, src2_0, src2_1, mask, fu, alu_op, reduce,
                base, stride, eew, stride_kind, nf, nf_count);

endinterface

//--- logic/exec_control.sv
/* issue and output handshake FSM with load and multiply start strobes */
module exec_control (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         in_valid,
  input  vex_pkg::fu_t in_fu,
  input  logic         out_ready,
  input  logic         timer_done,
  output logic         in_ready,
  output logic         out_valid,
  output logic         load,
  output logic         timer_start
);
  import vex_pkg::*;

  typedef enum logic [1:0] {IDLE, BUSY, FULL} state_t;

  state_t state;
  state_t state_next;
  logic   accept;
  logic   is_mul;

  // a held result may leave on the same edge a new one enters
  assign in_ready    = (state == IDLE) || ((state == FULL) && out_ready);
  assign accept      = in_valid && in_ready;
  assign is_mul      = in_fu == FU_MUL;
  assign load        = accept;
  assign timer_start = accept && is_mul;
  assign out_valid   = state == FULL;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (accept) state_next = is_mul ? BUSY : FULL;
      end
      BUSY: begin
        // multiply pending until the timer expires
        if (timer_done) state_next = FULL;
      end
      FULL: begin
        if (accept) state_next = is_mul ? BUSY : FULL;
        else if (out_ready) state_next = IDLE;
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

//--- logic/mul_timer.sv
/* multiply latency down-counter */
module mul_timer (
  input  logic CLK,
  input  logic nRST,
  input  logic start,
  output logic done
);
  import vex_pkg::*;

  logic [MUL_CNT_W-1:0] count;

  // loaded on the acceptance edge, expires two cycles later for latency 3
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else if (start) begin
      count <= MUL_CNT_W'(MUL_LATENCY - 1);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // last cycle before the result is presented
  assign done = count == MUL_CNT_W'(1);

endmodule

//--- logic/operand_latch.sv
/* first operand source select, immediate sign extension and
   the instruction holding register */
module operand_latch (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       load,
  input  vex_pkg::fu_t               fu,
  input  vex_pkg::alu_op_t           alu_op,
  input  vex_pkg::src_kind_t         src1_kind,
  input  logic                       reduce,
  input  logic [vex_pkg::XLEN-1:0]   vs1_0,
  input  logic [vex_pkg::XLEN-1:0]   vs1_1,
  input  logic [vex_pkg::XLEN-1:0]   vs2_0,
  input  logic [vex_pkg::XLEN-1:0]   vs2_1,
  input  logic [vex_pkg::XLEN-1:0]   xs1,
  input  logic [vex_pkg::XLEN-1:0]   xs2,
  input  logic [4:0]                 imm,
  input  vex_pkg::eew_t              eew,
  input  vex_pkg::stride_kind_t      stride_kind,
  input  logic [2:0]                 nf,
  input  logic [2:0]                 nf_count,
  lane_op_if.latch                   ops
);
  import vex_pkg::*;

  logic [XLEN-1:0] imm_ext;
  logic [XLEN-1:0] sel_0;
  logic [XLEN-1:0] sel_1;

  assign imm_ext = {{(XLEN-5){imm[4]}}, imm};

  always_comb begin
    case (src1_kind)
      SRC_I: begin
        sel_0 = imm_ext;
        sel_1 = imm_ext;
      end
      SRC_X: begin
        sel_0 = xs1;
        sel_1 = xs1;
      end
      default: begin
        sel_0 = vs1_0;
        sel_1 = vs1_1;
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ops.src1_0      <= '0;
      ops.src1_1      <= '0;
      ops.src2_0      <= '0;
      ops.src2_1      <= '0;
      ops.mask        <= '0;
      ops.fu          <= FU_ALU;
      ops.alu_op      <= ADD;
      ops.reduce      <= 1'b0;
      ops.base        <= '0;
      ops.stride      <= '0;
      ops.eew         <= EEW8;
      ops.stride_kind <= STRIDE_UNIT;
      ops.nf          <= '0;
      ops.nf_count    <= '0;
    end else if (load) begin
      ops.src1_0           <= sel_0;
      ops.src1_1           <= sel_1;
      ops.src2_0           <= vs2_0;
      ops.src2_1           <= vs2_1;
      // mask word is the same vs2 pair, viewed as lanes here
      ops.mask.lanes.lane0 <= vs2_0;
      ops.mask.lanes.lane1 <= vs2_1;
      ops.fu               <= fu;
      ops.alu_op           <= alu_op;
      ops.reduce           <= reduce;
      ops.base             <= xs1;
      ops.stride           <= xs2;
      ops.eew              <= eew;
      ops.stride_kind      <= stride_kind;
      ops.nf               <= nf;
      ops.nf_count         <= nf_count;
    end
  end

endmodule

//--- logic/lane_alu.sv
/* single lane element ALU and low-half multiply */
module lane_alu #(
  parameter int LANE = 0
) (
  lane_op_if.lane                  ops,
  output logic [vex_pkg::XLEN-1:0] lane_result
);
  import vex_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] mul_lo;
  logic [XLEN-1:0] alu_out;

  // operand pair of this lane
  always_comb begin
    if (LANE == 1) begin
      op_a = ops.src1_1;
      op_b = ops.src2_1;
    end else begin
      op_a = ops.src1_0;
      op_b = ops.src2_0;
    end
  end

  // low word only, sign does not matter here
  assign mul_lo = op_a * op_b;

  assign alu_out = alu_eval(ops.alu_op, op_a, op_b);

  // mem and find-first results come from result_merge, lane value ignored there
  always_comb begin
    case (ops.fu)
      FU_MUL:  lane_result = mul_lo;
      default: lane_result = alu_out;
    endcase
  end

endmodule

//--- logic/addr_gen.sv
/* load/store address generation for unit-stride, strided and segment access */
module addr_gen (
  lane_op_if.uses                  ops,
  output logic [vex_pkg::XLEN-1:0] addr0,
  output logic [vex_pkg::XLEN-1:0] addr1
);
  import vex_pkg::*;

  logic [XLEN-1:0] elem_bytes;
  logic [XLEN-1:0] field_off;
  logic [XLEN-1:0] step;

  always_comb begin
    case (ops.eew)
      EEW8:    elem_bytes = XLEN'(1);
      EEW16:   elem_bytes = XLEN'(2);
      default: elem_bytes = XLEN'(4);
    endcase
  end

  // field within the segment selects the starting element
  assign field_off = XLEN'(ops.nf_count) * elem_bytes;
  assign addr0     = ops.base + field_off;

  always_comb begin
    case (ops.stride_kind)
      STRIDE_CONST: step = ops.stride;
      // next segment starts nf+1 fields later
      STRIDE_SEG:   step = (XLEN'(ops.nf) + XLEN'(1)) * elem_bytes;
      default:      step = elem_bytes;
    endcase
  end

  assign addr1 = addr0 + step;

endmodule

//--- logic/result_merge.sv
/* two-lane reduction, find-first over the mask and output selection */
module result_merge (
  lane_op_if.uses                  ops,
  input  logic [vex_pkg::XLEN-1:0] lane0,
  input  logic [vex_pkg::XLEN-1:0] lane1,
  input  logic [vex_pkg::XLEN-1:0] addr0,
  input  logic [vex_pkg::XLEN-1:0] addr1,
  output logic [vex_pkg::XLEN-1:0] res0,
  output logic [vex_pkg::XLEN-1:0] res1,
  output logic [vex_pkg::XLEN-1:0] rd_data
);
  import vex_pkg::*;

  logic [XLEN-1:0] red_out;
  logic [XLEN-1:0] first_idx;

  assign red_out = alu_eval(ops.alu_op, lane0, lane1);

  // scan from the top so the lowest set bit wins
  always_comb begin
    first_idx = NO_FIRST;
    for (int i = 2*XLEN-1; i >= 0; i--) begin
      if (ops.mask.flat[i]) first_idx = XLEN'(i);
    end
  end

  always_comb begin
    res0    = '0;
    res1    = '0;
    rd_data = '0;
    case (ops.fu)
      FU_ALU: begin
        res0 = ops.reduce ? red_out : lane0;
        res1 = lane1;
      end
      FU_MUL: begin
        res0 = lane0;
        res1 = lane1;
      end
      FU_MEM: begin
        res0 = addr0;
        res1 = addr1;
      end
      default: begin
        rd_data = first_idx;
      end
    endcase
  end

endmodule

//--- logic/vex_execute.sv
/* two-lane vector execute stage top level */
module vex_execute (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  vex_pkg::fu_t               fu,
  input  vex_pkg::alu_op_t           alu_op,
  input  vex_pkg::src_kind_t         src1_kind,
  input  logic                       reduce,
  input  logic [vex_pkg::XLEN-1:0]   vs1_0,
  input  logic [vex_pkg::XLEN-1:0]   vs1_1,
  input  logic [vex_pkg::XLEN-1:0]   vs2_0,
  input  logic [vex_pkg::XLEN-1:0]   vs2_1,
  input  logic [vex_pkg::XLEN-1:0]   xs1,
  input  logic [vex_pkg::XLEN-1:0]   xs2,
  input  logic [4:0]                 imm,
  input  vex_pkg::eew_t              eew,
  input  vex_pkg::stride_kind_t      stride_kind,
  input  logic [2:0]                 nf,
  input  logic [2:0]                 nf_count,
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic [vex_pkg::XLEN-1:0]   res0,
  output logic [vex_pkg::XLEN-1:0]   res1,
  output logic [vex_pkg::XLEN-1:0]   rd_data
);
  import vex_pkg::*;

  logic            load;
  logic            timer_start;
  logic            timer_done;
  logic [XLEN-1:0] lane0;
  logic [XLEN-1:0] lane1;
  logic [XLEN-1:0] addr0;
  logic [XLEN-1:0] addr1;

  lane_op_if ops ();

  exec_control u_ctrl (
    .CLK(CLK), .nRST(nRST),
    .in_valid(in_valid), .in_fu(fu), .out_ready(out_ready), .timer_done(timer_done),
    .in_ready(in_ready), .out_valid(out_valid), .load(load), .timer_start(timer_start)
  );

  mul_timer u_timer (.CLK(CLK), .nRST(nRST), .start(timer_start), .done(timer_done));

  operand_latch u_latch (
    .CLK(CLK), .nRST(nRST), .load(load),
    .fu(fu), .alu_op(alu_op), .src1_kind(src1_kind), .reduce(reduce),
    .vs1_0(vs1_0), .vs1_1(vs1_1), .vs2_0(vs2_0), .vs2_1(vs2_1),
    .xs1(xs1), .xs2(xs2), .imm(imm),
    .eew(eew), .stride_kind(stride_kind), .nf(nf), .nf_count(nf_count),
    .ops(ops)
  );

  lane_alu #(.LANE(0)) u_lane0 (.ops(ops), .lane_result(lane0));
  lane_alu #(.LANE(1)) u_lane1 (.ops(ops), .lane_result(lane1));

  addr_gen u_addr (.ops(ops), .addr0(addr0), .addr1(addr1));

  result_merge u_merge (
    .ops(ops), .lane0(lane0), .lane1(lane1), .addr0(addr0), .addr1(addr1),
    .res0(res0), .res1(res1), .rd_data(rd_data)
  );

endmodule

//--- verif/tb_clock.sv
/* free-running testbench clock */
module tb_clock #(
  parameter int PERIOD = 40
) (
  output logic CLK
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

endmodule

//--- verif/vex_checker.sv
/* reference model of the execute stage, expected result queue,
   latency, ordering and hold checks on the output handshake */
module vex_checker (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     in_valid,
  input  logic                     in_ready,
  input  vex_pkg::fu_t             fu,
  input  vex_pkg::alu_op_t         alu_op,
  input  vex_pkg::src_kind_t       src1_kind,
  input  logic                     reduce,
  input  logic [vex_pkg::XLEN-1:0] vs1_0, vs1_1, vs2_0, vs2_1, xs1, xs2,
  input  logic [4:0]               imm,
  input  vex_pkg::eew_t            eew,
  input  vex_pkg::stride_kind_t    stride_kind,
  input  logic [2:0]               nf,
  input  logic [2:0]               nf_count,
  input  logic                     out_valid,
  input  logic                     out_ready,
  input  logic [vex_pkg::XLEN-1:0] res0, res1, rd_data,
  output int                       checked,
  output int                       errors
);
  import vex_pkg::*;

  // each entry is {res0, res1, rd_data}
  logic [3*XLEN-1:0] exp_q[$];
  logic [3*XLEN-1:0] held = '0;
  logic              holding = 1'b0;
  logic              pending = 1'b0;
  int                waited = 0;
  int                want_lat = 0;
  int                n_checked = 0;
  int                n_errors = 0;

  assign checked = n_checked;
  assign errors  = n_errors;

  function automatic logic [XLEN-1:0] apply_op(alu_op_t op, logic [XLEN-1:0] a,
                                               logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    sa = a;
    sb = b;
    case (op)
      ADD:     return a + b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      MIN:     return (sa < sb) ? a : b;
      MINU:    return (a < b) ? a : b;
      MAX:     return (sa > sb) ? a : b;
      default: return (a > b) ? a : b;
    endcase
  endfunction

  // lowest set index of {lane 1, lane 0}
  function automatic logic [XLEN-1:0] first_set(logic [2*XLEN-1:0] bits);
    for (int i = 0; i < 2*XLEN; i++) begin
      if (bits[i]) return XLEN'(i);
    end
    return NO_FIRST;
  endfunction

  function automatic logic [3*XLEN-1:0] expect_result();
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] a0;
    logic [XLEN-1:0] a1;
    logic [XLEN-1:0] l0;
    logic [XLEN-1:0] l1;
    logic [XLEN-1:0] eb;
    logic [XLEN-1:0] ad0;
    logic [XLEN-1:0] step;
    imm_ext = XLEN'($signed(imm));
    a0 = (src1_kind == SRC_I) ? imm_ext : (src1_kind == SRC_X) ? xs1 : vs1_0;
    a1 = (src1_kind == SRC_I) ? imm_ext : (src1_kind == SRC_X) ? xs1 : vs1_1;
    l0 = (fu == FU_MUL) ? a0 * vs2_0 : apply_op(alu_op, a0, vs2_0);
    l1 = (fu == FU_MUL) ? a1 * vs2_1 : apply_op(alu_op, a1, vs2_1);
    eb = (eew == EEW8) ? 32'd1 : (eew == EEW16) ? 32'd2 : 32'd4;
    ad0 = xs1 + XLEN'(nf_count) * eb;
    step = (stride_kind == STRIDE_CONST) ? xs2 :
           (stride_kind == STRIDE_SEG) ? (XLEN'(nf) + 32'd1) * eb : eb;
    case (fu)
      FU_ALU:  return {(reduce ? apply_op(alu_op, l0, l1) : l0), l1, {XLEN{1'b0}}};
      FU_MUL:  return {l0, l1, {XLEN{1'b0}}};
      FU_MEM:  return {ad0, ad0 + step, {XLEN{1'b0}}};
      default: return {{(2*XLEN){1'b0}}, first_set({vs2_1, vs2_0})};
    endcase
  endfunction

  task automatic compare_result(string what, logic [3*XLEN-1:0] want);
    logic [3*XLEN-1:0] seen;
    string names[3];
    seen = {res0, res1, rd_data};
    names = '{"rd_data", "res1", "res0"};
    for (int k = 0; k < 3; k++) begin
      if (seen[k*XLEN +: XLEN] !== want[k*XLEN +: XLEN]) begin
        $display("FAILED %s%s expected %08h got %08h", names[k], what,
                 want[k*XLEN +: XLEN], seen[k*XLEN +: XLEN]);
        n_errors++;
      end
    end
  endtask

  always @(posedge CLK) begin
    if (!nRST) begin
      if (out_valid !== 1'b0 || in_ready !== 1'b1 || {res0, res1, rd_data} !== '0) begin
        $display("handshake or results not cleared during reset");
        n_errors++;
      end
    end else begin
      // ready when idle, or when full and the result leaves
      if (in_ready !== (out_valid ? out_ready : !pending)) begin
        $display("FAILED in_ready expected %0h got %0h",
                 out_valid ? out_ready : !pending, in_ready);
        n_errors++;
      end
      // a stalled result must not move until consumed
      if (holding && !out_valid) begin
        $display("result withdrawn before it was consumed");
        n_errors++;
      end else if (holding) begin
        compare_result(" under back-pressure", held);
      end
      holding = out_valid && !out_ready;
      held = {res0, res1, rd_data};
      if (pending) begin
        waited++;
        if (out_valid) begin
          if (waited != want_lat) begin
            $display("result appeared %0d edges after acceptance, wanted %0d", waited, want_lat);
            n_errors++;
          end
          pending = 1'b0;
        end else if (waited > want_lat) begin
          $display("no result %0d edges after acceptance", waited);
          n_errors++;
          pending = 1'b0;
        end
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("output transfer with no instruction outstanding");
          n_errors++;
        end else begin
          compare_result("", exp_q.pop_front());
        end
        n_checked++;
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(expect_result());
        pending = 1'b1;
        waited = 0;
        want_lat = (fu == FU_MUL) ? MUL_LATENCY : 1;
      end
    end
  end

endmodule

//--- verif/tb_vex.sv
/* testbench top with seeded random stimulus, random back-pressure
   and a watchdog */
module tb_vex;
  import vex_pkg::*;

  localparam int PERIOD = 40;
  localparam int NUM_TXN = 600;
  // longest run of idle input or of stalled output
  localparam int STALL_MAX = 8;
  localparam int STALL_BOUND = 2 * STALL_MAX;
  localparam int WATCHDOG = (NUM_TXN + 4) * (MUL_LATENCY + STALL_BOUND) * PERIOD;

  logic            CLK;
  logic            nRST;
  logic            in_valid, in_ready, out_valid, out_ready, reduce;
  fu_t             fu;
  alu_op_t         alu_op;
  src_kind_t       src1_kind;
  eew_t            eew;
  stride_kind_t    stride_kind;
  logic [XLEN-1:0] vs1_0, vs1_1, vs2_0, vs2_1, xs1, xs2;
  logic [XLEN-1:0] res0, res1, rd_data;
  logic [4:0]      imm;
  logic [2:0]      nf, nf_count;
  int              checked;
  int              errors;
  int              sent = 0;
  int              in_gap = 0;
  int              out_stall = 0;

  tb_clock #(.PERIOD(PERIOD)) u_clock (.CLK(CLK));

  vex_execute vex_execute_inst (.*);

  vex_checker u_check (.*);

  task automatic draw_instr();
    int unsigned pick;
    pick = $urandom_range(0, 3);
    fu          <= fu_t'(2'($urandom_range(0, 3)));
    alu_op      <= alu_op_t'(3'($urandom()));
    src1_kind   <= src_kind_t'(2'($urandom_range(0, 2)));
    reduce      <= 1'($urandom());
    vs1_0       <= $urandom();
    vs1_1       <= $urandom();
    // empty lane 0 or empty mask now and then, for find-first
    vs2_0       <= (pick <= 1) ? 32'd0 : $urandom();
    vs2_1       <= (pick == 1) ? 32'd0 : ($urandom() & $urandom());
    xs1         <= $urandom();
    xs2         <= $urandom();
    imm         <= 5'($urandom());
    eew         <= eew_t'(2'($urandom_range(0, 2)));
    stride_kind <= stride_kind_t'(2'($urandom_range(0, 2)));
    nf          <= 3'($urandom());
    nf_count    <= 3'($urandom());
  endtask

  always @(posedge CLK) begin
    if (nRST) begin
      if (in_valid && in_ready) sent = sent + 1;
      if (in_valid && !in_ready) begin
        // fields stay put until accepted
      end else if (sent < NUM_TXN && (in_gap >= STALL_MAX || $urandom_range(0, 3) != 0)) begin
        in_valid <= 1'b1;
        draw_instr();
        in_gap = 0;
      end else begin
        in_valid <= 1'b0;
        in_gap = in_gap + 1;
      end
      if (out_stall >= STALL_MAX || $urandom_range(0, 2) != 0) begin
        out_ready <= 1'b1;
        out_stall = 0;
      end else begin
        out_ready <= 1'b0;
        out_stall = out_stall + 1;
      end
    end
  end

  initial begin
    void'($urandom(32'he192dd5f));
    {in_valid, out_ready, reduce} = '0;
    fu          = FU_ALU;
    alu_op      = ADD;
    src1_kind   = SRC_V;
    eew         = EEW8;
    stride_kind = STRIDE_UNIT;
    {vs1_0, vs1_1, vs2_0, vs2_1, xs1, xs2} = '0;
    {imm, nf, nf_count} = '0;
    nRST = 1'b1;
    #1 nRST = 1'b0;
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    wait (checked == NUM_TXN);
    repeat (4) @(posedge CLK);
    $display("results checked %0d, errors %0d", checked, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG);
    $display("timeout with %0d of %0d results checked, errors %0d", checked, NUM_TXN, errors);
    $display("Regression failed");
    $finish;
  end

endmodule

//--- filelist.f
logic/vex_pkg.sv
logic/lane_op_if.sv
logic/exec_control.sv
logic/mul_timer.sv
logic/operand_latch.sv
logic/lane_alu.sv
logic/addr_gen.sv
logic/result_merge.sv
logic/vex_execute.sv
verif/tb_clock.sv
verif/vex_checker.sv
verif/tb_vex.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -j 0 --top-module tb_vex -Mdir obj_dir -f filelist.f
	@out="$$(./obj_dir/Vtb_vex)"; echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
